// File: rtl/spi_params.svh
//**************************************************
// spi slave frame parameters
// word width, synchronizer depth, edges per frame
//**************************************************
`ifndef SPI_PARAMS_SVH
`define SPI_PARAMS_SVH

// bits per spi frame, msb first on the wire
`define SPI_WORD_BITS 8

// flop depth of the pin synchronizers
`define SPI_SYNC_STAGES 2

// every bit costs a leading and a trailing sclk edge
`define SPI_EDGES_PER_WORD (2 * `SPI_WORD_BITS)

`endif

// File: rtl/spi_mode_pkg.sv
//**************************************************
// spi_mode_pkg
// transfer FSM states and sclk edge roles
//**************************************************
package spi_mode_pkg;

	// one byte transfer, walked once per cs window
	typedef enum logic [2:0] {
		st_idle      = 3'd0,	// cs high or frame done
		st_load      = 3'd1,	// tx byte into shifter
		st_wait_edge = 3'd2,	// waiting on next sclk edge
		st_edge      = 3'd3,	// one edge handled, count it
		st_last_half = 3'd4,	// settle after edge 16
		st_capture   = 3'd5,	// hand byte to host side
		st_finish    = 3'd6	// one spare cycle before idle
	} xfer_state_t;

	// what an sclk edge does to the data
	typedef enum logic {
		role_sample = 1'b0,	// mosi taken in
		role_launch = 1'b1	// next miso bit driven
	} edge_role_t;

endpackage

// File: rtl/spi_data_pkg.sv
//**************************************************
// spi_data_pkg
// payload byte and edge counter types
//**************************************************
`include "spi_params.svh"

package spi_data_pkg;

	// one frame of payload, msb first on the wire
	typedef logic [`SPI_WORD_BITS-1:0] spi_byte_t;

	// must hold 0 up to and including SPI_EDGES_PER_WORD
	typedef logic [$clog2(`SPI_EDGES_PER_WORD + 1)-1:0] edge_cnt_t;

endpackage

// File: rtl/spi_pin_sync.sv
//**************************************************
// spi_pin_sync
// brings cs, sclk, mosi into sys_clk and finds
// cs and sclk edges, sclk edges tagged by role
//**************************************************
`include "spi_params.svh"

module spi_pin_sync #(
	parameter bit CPOL = 1'b1,	// sclk idle level
	parameter bit CPHA = 1'b1	// 1: sample on trailing edge
) (
	input  logic sys_clk,
	input  logic sys_rst_n,
	input  logic cs,
	input  logic sclk,
	input  logic mosi,
	output logic cs_s,
	output logic cs_fall,
	output logic cs_rise,
	output logic sample_edge,
	output logic launch_edge,
	output logic mosi_s
);

	localparam int SYNC = `SPI_SYNC_STAGES;

	logic [SYNC-1:0] cs_sync;	// pin enters at bit 0
	logic [SYNC-1:0] sclk_sync;
	logic [SYNC-1:0] mosi_sync;
	logic cs_prev;	// last synced cs
	logic sclk_prev;	// last synced sclk
	logic sclk_s;
	logic lead_edge;
	logic trail_edge;

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			cs_sync   <= '1;	// deselected, no false fall
			sclk_sync <= {SYNC{CPOL}};	// park at idle level
			mosi_sync <= '0;
			cs_prev   <= 1'b1;
			sclk_prev <= CPOL;
		end else begin
			cs_sync   <= {cs_sync[SYNC-2:0], cs};
			sclk_sync <= {sclk_sync[SYNC-2:0], sclk};
			mosi_sync <= {mosi_sync[SYNC-2:0], mosi};
			cs_prev   <= cs_s;
			sclk_prev <= sclk_s;
		end
	end

	assign cs_s    = cs_sync[SYNC-1];
	assign sclk_s  = sclk_sync[SYNC-1];
	assign mosi_s  = mosi_sync[SYNC-1];
	assign cs_fall = cs_prev & ~cs_s;
	assign cs_rise = ~cs_prev & cs_s;

	assign lead_edge  = (sclk_prev == CPOL) && (sclk_s != CPOL);	// leaves idle level
	assign trail_edge = (sclk_prev != CPOL) && (sclk_s == CPOL);	// back to idle

	assign sample_edge = CPHA ? trail_edge : lead_edge;
	assign launch_edge = CPHA ? lead_edge : trail_edge;

	// one sclk transition can only carry one role
	a_edge_roles_excl : assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!(sample_edge && launch_edge));

endmodule

// File: rtl/spi_bit_counter.sv
//**************************************************
// spi_bit_counter
// counts sclk edges within one byte
//**************************************************
`include "spi_params.svh"

module spi_bit_counter (
	input  logic                   sys_clk,
	input  logic                   sys_rst_n,
	input  logic                   cnt_clr,
	input  logic                   cnt_step,
	output spi_data_pkg::edge_cnt_t edge_cnt,
	output logic                   last_edge
);

	import spi_data_pkg::*;

	localparam edge_cnt_t EDGE_LAST = edge_cnt_t'(`SPI_EDGES_PER_WORD);

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			edge_cnt <= '0;
		end else if (cnt_clr) begin
			edge_cnt <= '0;	// new frame or aborted one
		end else if (cnt_step) begin
			edge_cnt <= edge_cnt + edge_cnt_t'(1);
		end
	end

	assign last_edge = (edge_cnt == EDGE_LAST);	// all edges of byte seen

	// FSM must leave the edge loop once the byte is complete
	a_no_step_past_last : assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		cnt_step |-> !last_edge);

endmodule

// File: rtl/spi_xfer_fsm.sv
//**************************************************
// spi_xfer_fsm
// sequences one byte: load, sixteen edges, capture
//**************************************************
module spi_xfer_fsm (
	input  logic                    sys_clk,
	input  logic                    sys_rst_n,
	input  logic                    cs_s,
	input  logic                    cs_fall,
	input  logic                    sample_edge,
	input  logic                    launch_edge,
	input  logic                    last_edge,
	input  spi_data_pkg::edge_cnt_t edge_cnt,
	output logic                    cnt_clr,
	output logic                    cnt_step,
	output logic                    load,
	output logic                    sample_en,
	output logic                    launch_en,
	output logic                    capture
);

	import spi_mode_pkg::*;
	import spi_data_pkg::*;

	xfer_state_t state;
	xfer_state_t state_nxt;
	logic        in_loop;	// waiting on an edge, byte not done
	logic        first_edge;	// nothing counted yet this frame

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			state <= st_idle;
		else
			state <= state_nxt;
	end

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle:      if (cs_fall) state_nxt = st_load;
			st_load:      state_nxt = st_wait_edge;
			st_wait_edge: begin
				if (last_edge)
					state_nxt = st_last_half;	// edge 16 already counted
				else if (sample_edge || launch_edge)
					state_nxt = st_edge;
			end
			st_edge:      state_nxt = st_wait_edge;
			st_last_half: state_nxt = st_capture;
			st_capture:   state_nxt = st_finish;
			st_finish:    state_nxt = st_idle;	// needs a fresh cs fall
			default:      state_nxt = st_idle;
		endcase
		// cs going high kills the frame, partial byte lost
		if (cs_s && state != st_idle)
			state_nxt = st_idle;
	end

	assign in_loop    = (state == st_wait_edge) && !last_edge;
	assign first_edge = (edge_cnt == '0);

	assign cnt_clr   = (state == st_idle) || (state == st_load);
	assign cnt_step  = (state == st_edge);
	assign load      = (state == st_load);
	assign sample_en = in_loop && sample_edge;
	// with CPHA 1 the first edge launches, but bit 7 is on miso since load
	assign launch_en = in_loop && launch_edge && !first_edge;
	assign capture   = (state == st_capture);

	// host side latches on a single strobe per byte
	a_capture_one_cycle : assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		capture |=> !capture);

endmodule

// File: rtl/spi_shift_unit.sv
//**************************************************
// spi_shift_unit
// miso transmit shifter and mosi receive shifter,
// both msb first
//**************************************************
`include "spi_params.svh"

module spi_shift_unit (
	input  logic                    sys_clk,
	input  logic                    sys_rst_n,
	input  logic                    load,
	input  logic                    sample_en,
	input  logic                    launch_en,
	input  logic                    mosi_s,
	input  spi_data_pkg::spi_byte_t tx_data,
	output logic                    miso,
	output spi_data_pkg::spi_byte_t rx_shift
);

	import spi_data_pkg::*;
	import spi_mode_pkg::*;

	localparam int W = `SPI_WORD_BITS;

	spi_byte_t  tx_reg;	// msb is on the pin
	spi_byte_t  rx_reg;
	edge_role_t last_role;	// role of the previous shift

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			tx_reg <= '0;	// keeps miso low out of reset
		else if (load)
			tx_reg <= tx_data;	// tx_data held while cs low
		else if (launch_en)
			tx_reg <= {tx_reg[W-2:0], 1'b0};
	end

	always_ff @(posedge sys_clk) begin
		if (load)
			rx_reg <= '0;
		else if (sample_en)
			rx_reg <= {rx_reg[W-2:0], mosi_s};	// first bit ends at msb
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			last_role <= role_launch;
		else if (load)
			last_role <= role_launch;	// frame opens with a sample
		else if (sample_en)
			last_role <= role_sample;
		else if (launch_en)
			last_role <= role_launch;
	end

	assign miso     = tx_reg[W-1];
	assign rx_shift = rx_reg;

	a_load_no_shift : assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		load |-> !(sample_en || launch_en));

	// sample and launch alternate in every mode once the first launch is skipped
	a_roles_alternate : assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(sample_en |-> last_role == role_launch) and
		(launch_en |-> last_role == role_sample));

endmodule

// File: rtl/spi_rx_handshake.sv
//**************************************************
// spi_rx_handshake
// holds the received byte, four-phase req/ack
// to the host, sticky overrun on a dropped byte
//**************************************************
module spi_rx_handshake (
	input  logic                    sys_clk,
	input  logic                    sys_rst_n,
	input  logic                    capture,
	input  spi_data_pkg::spi_byte_t rx_shift,
	input  logic                    rx_ack,
	output logic                    rx_req,
	output spi_data_pkg::spi_byte_t rx_data,
	output logic                    rx_overrun
);

	import spi_data_pkg::*;

	typedef enum logic [1:0] {
		hs_empty        = 2'd0,	// free for a new byte
		hs_req_high     = 2'd1,	// byte offered, waiting ack
		hs_wait_ack_low = 2'd2	// ack seen, waiting release
	} hs_state_t;

	hs_state_t hs_state;

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			hs_state   <= hs_empty;
			rx_overrun <= 1'b0;
		end else begin
			case (hs_state)
				hs_empty:        if (capture) hs_state <= hs_req_high;
				hs_req_high:     if (rx_ack) hs_state <= hs_wait_ack_low;
				hs_wait_ack_low: if (!rx_ack) hs_state <= hs_empty;
				default:         hs_state <= hs_empty;
			endcase
			if (capture && hs_state != hs_empty)
				rx_overrun <= 1'b1;	// stays until reset
		end
	end

	always_ff @(posedge sys_clk) begin
		if (capture && hs_state == hs_empty)
			rx_data <= rx_shift;	// dropped byte never lands here
	end

	assign rx_req = (hs_state == hs_req_high);

	// host may sample rx_data at any point of the request
	a_data_stable_req : assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(rx_req && $past(rx_req)) |-> $stable(rx_data));

endmodule

// File: rtl/spi_slave_top.sv
//**************************************************
// spi_slave_top
// single byte spi slave, host side req/ack
//**************************************************
module spi_slave_top #(
	parameter bit CPOL = 1'b1,	// mode 3 by default
	parameter bit CPHA = 1'b1
) (
	input  logic                    sys_clk,
	input  logic                    sys_rst_n,
	input  logic                    cs,
	input  logic                    sclk,
	input  logic                    mosi,
	output logic                    miso,
	input  spi_data_pkg::spi_byte_t tx_data,
	output logic                    rx_req,
	input  logic                    rx_ack,
	output spi_data_pkg::spi_byte_t rx_data,
	output logic                    rx_overrun
);

	import spi_data_pkg::*;

	logic      cs_s;
	logic      cs_fall;
	logic      sample_edge;
	logic      launch_edge;
	logic      mosi_s;
	logic      cnt_clr;
	logic      cnt_step;
	logic      last_edge;
	edge_cnt_t edge_cnt;
	logic      load;
	logic      sample_en;
	logic      launch_en;
	logic      capture;
	spi_byte_t rx_shift;

	spi_pin_sync #(
		.CPOL(CPOL),
		.CPHA(CPHA)
	) u_pin_sync (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.cs         (cs),
		.sclk       (sclk),
		.mosi       (mosi),
		.cs_s       (cs_s),
		.cs_fall    (cs_fall),
		.cs_rise    (),	// abort goes off the cs level
		.sample_edge(sample_edge),
		.launch_edge(launch_edge),
		.mosi_s     (mosi_s)
	);

	spi_bit_counter u_bit_counter (
		.sys_clk  (sys_clk),
		.sys_rst_n(sys_rst_n),
		.cnt_clr  (cnt_clr),
		.cnt_step (cnt_step),
		.edge_cnt (edge_cnt),
		.last_edge(last_edge)
	);

	spi_xfer_fsm u_xfer_fsm (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.cs_s       (cs_s),
		.cs_fall    (cs_fall),
		.sample_edge(sample_edge),
		.launch_edge(launch_edge),
		.last_edge  (last_edge),
		.edge_cnt   (edge_cnt),
		.cnt_clr    (cnt_clr),
		.cnt_step   (cnt_step),
		.load       (load),
		.sample_en  (sample_en),
		.launch_en  (launch_en),
		.capture    (capture)
	);

	spi_shift_unit u_shift_unit (
		.sys_clk  (sys_clk),
		.sys_rst_n(sys_rst_n),
		.load     (load),
		.sample_en(sample_en),
		.launch_en(launch_en),
		.mosi_s   (mosi_s),
		.tx_data  (tx_data),
		.miso     (miso),
		.rx_shift (rx_shift)
	);

	spi_rx_handshake u_rx_handshake (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.capture   (capture),
		.rx_shift  (rx_shift),
		.rx_ack    (rx_ack),
		.rx_req    (rx_req),
		.rx_data   (rx_data),
		.rx_overrun(rx_overrun)
	);

endmodule

// File: tb/tb_clk_gen.sv
//**************************************************
// tb_clk_gen
// sys_clk with an 8 unit period, reset low 8 cycles
//**************************************************
module tb_clk_gen #(
	parameter int HALF_PERIOD = 4,	// 8 unit period
	parameter int RST_CYCLES  = 8
) (
	output logic sys_clk,
	output logic sys_rst_n
);

	initial begin
		sys_clk = 1'b0;
		forever #HALF_PERIOD sys_clk = ~sys_clk;
	end

	initial begin
		sys_rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge sys_clk);
		#1;	// release off the edge like other stimulus
		sys_rst_n = 1'b1;
	end

endmodule

// File: tb/tb_spi_slave.sv
//**************************************************
// tb_spi_slave
// spi master and host models around the slave,
// rx_data and miso checked against a reference
//**************************************************
`include "spi_params.svh"

module tb_spi_slave #(
	parameter bit CPOL = 1'b1,	// mode 3 unless overridden
	parameter bit CPHA = 1'b1
);

	import spi_data_pkg::*;

	localparam int W              = `SPI_WORD_BITS;
	localparam int N_RANDOM       = 40;	// random full frames
	localparam int N_FRAMES       = N_RANDOM + 4;	// abort, recovery, two overrun
	localparam int HALF           = 5;	// sclk half period in sys_clk
	localparam int CS_SETUP       = 6;	// cs fall to first sclk edge
	localparam int CS_HOLD        = 8;	// capture done before cs rises
	localparam int CS_GAP         = 6;	// cs high between frames
	localparam int FRAME_CYCLES   = CS_SETUP + 2 * W * HALF + CS_HOLD + CS_GAP;
	localparam int HS_ALLOW       = 40;	// ack delay plus idle windows
	localparam int TIMEOUT_CYCLES = N_FRAMES * (FRAME_CYCLES + HS_ALLOW) * 2;
	localparam logic [31:0] LFSR_SEED = 32'd72903;
	localparam logic [31:0] LFSR_TAPS = 32'hA300_0000;	// x^32+x^30+x^26+x^25+1

	logic      sys_clk;
	logic      sys_rst_n;
	logic      cs;
	logic      sclk;
	logic      mosi;
	logic      miso;
	spi_byte_t tx_data;
	logic      rx_req;
	logic      rx_ack;
	spi_byte_t rx_data;
	logic      rx_overrun;

	logic        ack_hold;	// host withholds rx_ack while set
	logic        req_prev = 1'b0;
	logic        ack_prev = 1'b0;
	logic        ack_seen = 1'b0;	// ack during current request
	int          rx_idx = 0;	// requests checked so far
	int          cycle_cnt = 0;
	spi_byte_t   exp_rx_q[$];	// one entry per expected request
	logic [31:0] lfsr_main;

	tb_clk_gen u_clk_gen (
		.sys_clk  (sys_clk),
		.sys_rst_n(sys_rst_n)
	);

	spi_slave_top #(
		.CPOL(CPOL),
		.CPHA(CPHA)
	) uut (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.cs        (cs),
		.sclk      (sclk),
		.mosi      (mosi),
		.miso      (miso),
		.tx_data   (tx_data),
		.rx_req    (rx_req),
		.rx_ack    (rx_ack),
		.rx_data   (rx_data),
		.rx_overrun(rx_overrun)
	);

	function automatic logic [31:0] galois_step(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0])
			n = n ^ LFSR_TAPS;	// feedback only when a one falls out
		return n;
	endfunction

	task automatic rand_bits(inout logic [31:0] state, input int nbits,
			output spi_byte_t value);
		value = '0;
		for (int i = 0; i < nbits; i++) begin
			state = galois_step(state);	// one step per bit
			value = {value[W-2:0], state[0]};
		end
	endtask

	// msb first both ways, slave returns the mosi byte as is
	function automatic void spi_expect(input spi_byte_t mosi_b, input spi_byte_t tx_b,
			output spi_byte_t rx_exp, output spi_byte_t miso_exp);
		rx_exp   = '0;
		miso_exp = '0;
		for (int i = 0; i < W; i++) begin
			rx_exp   = {rx_exp[W-2:0], mosi_b[W-1-i]};
			miso_exp = {miso_exp[W-2:0], tx_b[W-1-i]};	// first bit seen ends at msb
		end
	endfunction

	task automatic stop_on_error(input string line);
		$display("%s", line);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic next_cycle();
		@(posedge sys_clk);
		#1;	// inputs move just after the edge
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) next_cycle();
	endtask

	// master side of one frame, n_bits short of W means abort
	task automatic run_frame(input spi_byte_t mosi_b, input spi_byte_t tx_b,
			input int n_bits, output spi_byte_t miso_seen);
		int mi;
		miso_seen = '0;
		tx_data   = tx_b;
		mi        = W - 1;
		if (!CPHA) begin
			mosi = mosi_b[mi];	// first bit before the first edge
			mi   = mi - 1;
		end
		cs = 1'b0;
		idle_cycles(CS_SETUP);
		for (int e = 0; e < 2 * n_bits; e++) begin
			sclk = ~sclk;	// even e leaves idle level
			if (((e % 2) == 1) == CPHA) begin
				miso_seen = {miso_seen[W-2:0], miso};
			end else if (mi >= 0) begin
				mosi = mosi_b[mi];
				mi   = mi - 1;
			end
			idle_cycles(HALF);
		end
		idle_cycles(CS_HOLD);
		cs   = 1'b1;
		mosi = 1'b0;
		idle_cycles(CS_GAP);
	endtask

	task automatic send_frame(input spi_byte_t mosi_b, input spi_byte_t tx_b,
			input bit want_req);
		spi_byte_t rx_exp;
		spi_byte_t miso_exp;
		spi_byte_t miso_seen;
		spi_expect(mosi_b, tx_b, rx_exp, miso_exp);
		if (want_req)
			exp_rx_q.push_back(rx_exp);	// queued before req can rise
		run_frame(mosi_b, tx_b, W, miso_seen);
		assert (miso_seen == miso_exp) else
			stop_on_error($sformatf("[FAIL] %0t: miso bits %02h, expected %02h",
				$time, miso_seen, miso_exp));
	endtask

	task automatic wait_hs_idle();
		while (rx_idx < exp_rx_q.size() || rx_req || rx_ack)
			next_cycle();
	endtask

	// host answers each request after 0 to 3 cycles
	initial begin : host_model
		logic [31:0] lfsr_host;
		spi_byte_t   delay;
		lfsr_host = LFSR_SEED;
		rx_ack    = 1'b0;
		forever begin
			next_cycle();
			if (rx_req && !rx_ack && !ack_hold) begin
				rand_bits(lfsr_host, 2, delay);
				repeat (delay) next_cycle();
				rx_ack = 1'b1;
				while (rx_req)
					next_cycle();
				rx_ack = 1'b0;	// release once req is gone
			end
		end
	end

	// req/ack order and rx_data, sampled mid cycle
	always @(negedge sys_clk) begin
		if (sys_rst_n) begin
			if (rx_req && !req_prev) begin
				ack_seen = 1'b0;
				assert (!ack_prev) else
					stop_on_error($sformatf("rx_req rose at %0t while rx_ack was still high",
						$time));
				assert (rx_idx < exp_rx_q.size()) else
					stop_on_error($sformatf("rx_req rose at %0t with no frame sent for it",
						$time));
				assert (rx_data == exp_rx_q[rx_idx]) else
					stop_on_error($sformatf("[FAIL] %0t: rx_data %02h, expected %02h",
						$time, rx_data, exp_rx_q[rx_idx]));
				rx_idx = rx_idx + 1;
			end
			if (rx_req && rx_ack)
				ack_seen = 1'b1;
			if (!rx_req && req_prev) begin
				assert (ack_seen) else
					stop_on_error($sformatf("rx_req fell at %0t before rx_ack rose", $time));
			end
		end
		req_prev = rx_req;
		ack_prev = rx_ack;
	end

	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
			stop_on_error($sformatf("timeout after %0d cycles, a frame or handshake hung",
				cycle_cnt));
	end

	initial begin : main_seq
		spi_byte_t mosi_b;
		spi_byte_t tx_b;
		spi_byte_t first_b;
		spi_byte_t abort_seen;
		cs        = 1'b1;
		sclk      = CPOL;
		mosi      = 1'b0;
		tx_data   = '0;
		ack_hold  = 1'b0;
		lfsr_main = LFSR_SEED;
		wait (sys_rst_n == 1'b1);
		next_cycle();

		// reset values
		assert (rx_req == 1'b0) else
			stop_on_error($sformatf("[FAIL] %0t: rx_req high after reset", $time));
		assert (rx_overrun == 1'b0) else
			stop_on_error($sformatf("[FAIL] %0t: rx_overrun high after reset", $time));
		assert (miso == 1'b0) else
			stop_on_error($sformatf("[FAIL] %0t: miso high after reset", $time));

		for (int n = 0; n < N_RANDOM; n++) begin
			rand_bits(lfsr_main, W, mosi_b);
			rand_bits(lfsr_main, W, tx_b);
			send_frame(mosi_b, tx_b, 1'b1);
			wait_hs_idle();
		end

		// abort after half a byte, overrun is sticky so this goes first
		rand_bits(lfsr_main, W, mosi_b);
		rand_bits(lfsr_main, W, tx_b);
		run_frame(mosi_b, tx_b, W / 2, abort_seen);
		assert (abort_seen[W/2-1:0] == tx_b[W-1:W/2]) else
			stop_on_error($sformatf("[FAIL] %0t: aborted frame miso %01h, expected %01h",
				$time, abort_seen[W/2-1:0], tx_b[W-1:W/2]));
		idle_cycles(40);
		assert (rx_req == 1'b0) else
			stop_on_error($sformatf("[FAIL] %0t: rx_req after an aborted frame", $time));
		rand_bits(lfsr_main, W, mosi_b);
		rand_bits(lfsr_main, W, tx_b);
		send_frame(mosi_b, tx_b, 1'b1);	// recovery frame
		wait_hs_idle();

		// nothing dropped so far
		assert (rx_overrun == 1'b0) else
			stop_on_error($sformatf("[FAIL] %0t: rx_overrun set with no byte dropped",
				$time));

		// overrun, second byte lands while the first is still offered
		ack_hold = 1'b1;
		rand_bits(lfsr_main, W, first_b);
		rand_bits(lfsr_main, W, tx_b);
		send_frame(first_b, tx_b, 1'b1);
		while (!rx_req)
			next_cycle();
		mosi_b = ~first_b;	// differs in every bit
		rand_bits(lfsr_main, W, tx_b);
		send_frame(mosi_b, tx_b, 1'b0);
		idle_cycles(10);
		assert (rx_data == first_b) else
			stop_on_error($sformatf("[FAIL] %0t: rx_data %02h, expected %02h after overrun",
				$time, rx_data, first_b));
		assert (rx_overrun == 1'b1) else
			stop_on_error($sformatf("[FAIL] %0t: rx_overrun not set", $time));
		ack_hold = 1'b0;
		wait_hs_idle();
		idle_cycles(40);	// no request for the dropped byte
		assert (rx_overrun == 1'b1) else
			stop_on_error($sformatf("[FAIL] %0t: rx_overrun cleared before reset", $time));

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// File: project.f
+incdir+rtl
rtl/spi_mode_pkg.sv
rtl/spi_data_pkg.sv
rtl/spi_pin_sync.sv
rtl/spi_bit_counter.sv
rtl/spi_xfer_fsm.sv
rtl/spi_shift_unit.sv
rtl/spi_rx_handshake.sv
rtl/spi_slave_top.sv
tb/tb_clk_gen.sv
tb/tb_spi_slave.sv

// File: Makefile
# Verilator build and run of the SPI slave testbench

VERILATOR  ?= verilator
TOP        ?= tb_spi_slave
FILELIST   ?= project.f
OBJ_DIR    ?= obj_dir
CPOL       ?= 1
CPHA       ?= 1
VFLAGS     ?= --binary --timing --assert --Mdir $(OBJ_DIR)
LINT_FLAGS ?= --lint-only --timing
PARAMS     = -GCPOL=$(CPOL) -GCPHA=$(CPHA)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) $(PARAMS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) $(PARAMS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
